// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the testbench with verilator and run it"
	@echo "make clean  remove the verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_soc -f compile.f --Mdir obj_dir -o sim_tb_soc
	@out="$$(./obj_dir/sim_tb_soc 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== compile.f ====
soc_pkg.sv
data_bus_if.sv
data_bus_decoder.sv
dual_port_bram.sv
uart_tx.sv
peripheral_block.sv
soc_memory_subsystem.sv
tb_clock_gen.sv
tb_soc.sv

// ==== data_bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_bus_decoder (
    input  logic       clk,
    input  logic       arst_n,
    data_bus_if.slave  master, // from the bus master
    data_bus_if.master bram,   // ram segment
    data_bus_if.master periph  // peripheral segment
);
    import soc_pkg::*;

    logic is_bram;    // address falls in the ram window
    logic bram_sel;   // ram access this cycle
    logic periph_sel; // peripheral access this cycle
    logic bram_sel_q; // target of the last access, picks rdata

    assign is_bram    = (master.addr <= bram_limit);
    assign bram_sel   = master.en && is_bram;
    assign periph_sel = master.en && !is_bram;

    // address and data fan out to both segments
    assign bram.en     = bram_sel;
    assign bram.addr   = master.addr;
    assign bram.wdata  = master.wdata;
    assign bram.write  = bram_sel ? master.write : '0; // mask only on the selected side

    assign periph.en    = periph_sel;
    assign periph.addr  = master.addr;
    assign periph.wdata = master.wdata;
    assign periph.write = periph_sel ? master.write : '0;

    // remember which target answered, rdata comes back one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bram_sel_q <= 1'b1; // ram by default
        end else if (master.en) begin
            bram_sel_q <= is_bram; // hold across idle cycles
        end
    end

    assign master.rdata = bram_sel_q ? bram.rdata : periph.rdata;

    // the two segments must never be accessed in the same cycle
    assert property (@(posedge clk) disable iff (!arst_n)
        !(bram.en && periph.en))
        else $error("ram and peripheral enables high together");

endmodule : data_bus_decoder

`default_nettype wire

// ==== data_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one segment of the data bus, plain enable plus byte-write strobes
interface data_bus_if;
    import soc_pkg::*;

    logic     en;    // access strobe, one cycle per access
    byte_en_t write; // nonzero mask means write, zero means read
    word_t    addr;  // byte address
    word_t    wdata; // write data, lanes selected by write
    word_t    rdata; // read data, valid the cycle after a read

    modport master (
        output en,
        output write,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  en,
        input  write,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface : data_bus_if

`default_nettype wire

// ==== dual_port_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_port_bram #(
    parameter int bram_words = 1024 // depth in 32-bit words
) (
    input  logic           clk,
    input  logic           instr_en,    // instruction fetch strobe
    input  soc_pkg::word_t instr_addr,  // fetch byte address
    output soc_pkg::word_t instruction, // fetched word, one cycle later
    data_bus_if.slave      data         // byte-writable data port
);
    import soc_pkg::*;

    localparam int idx_w = (bram_words > 1) ? $clog2(bram_words) : 1;

    word_t             mem [bram_words]; // shared storage for both ports
    logic [idx_w-1:0]  instr_idx;        // word index on port a
    logic [idx_w-1:0]  data_idx;         // word index on port b

    // word index from bits above bit 1, wrapped to the depth
    assign instr_idx = idx_w'((instr_addr >> 2) % bram_words);
    assign data_idx  = idx_w'((data.addr >> 2) % bram_words);

    // port a, read only, holds the last fetch while idle
    always_ff @(posedge clk) begin
        if (instr_en) begin
            instruction <= mem[instr_idx];
        end
    end

    // port b, lane writes and registered reads
    always_ff @(posedge clk) begin
        if (data.en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (data.write[lane]) begin
                    mem[data_idx][lane*8 +: 8] <= data.wdata[lane*8 +: 8];
                end
            end
            data.rdata <= mem[data_idx]; // old word on a write, not meant to be used
        end
    end

    // the decoder only forwards a mask on the segment it enables
    assert property (@(posedge clk) (data.write != '0) |-> data.en)
        else $error("ram write mask set without enable");

endmodule : dual_port_bram

`default_nettype wire

// ==== peripheral_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module peripheral_block #(
    parameter int clks_per_bit = 8 // uart bit length in cycles
) (
    input  logic           clk,
    input  logic           arst_n,
    data_bus_if.slave      bus,        // peripheral segment of the data bus
    output soc_pkg::byte_t gpioa_out,  // gpio output register
    output soc_pkg::byte_t gpioa_addr, // gpio address register
    output logic           uart_tx,    // serial output
    output logic           stall       // high while a uart frame is in flight
);
    import soc_pkg::*;

    logic  wr_low;     // write that touches byte lane 0
    logic  rd;         // read access
    logic  uart_start; // accepted byte for the uart
    logic  uart_busy;  // frame in progress
    byte_t uart_byte;  // byte handed to the serializer

    assign wr_low = bus.en && bus.write[0];
    assign rd     = bus.en && (bus.write == '0);

    // a byte written while the uart is busy is dropped
    assign uart_start = wr_low && (bus.addr == uart_data_addr) && !uart_busy;
    assign uart_byte  = bus.wdata[7:0];

    // gpio registers, only lane 0 is backed by storage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpioa_out  <= '0;
            gpioa_addr <= '0;
        end else if (wr_low) begin
            if (bus.addr == gpio_out_addr) begin
                gpioa_out <= bus.wdata[7:0];
            end
            if (bus.addr == gpio_addr_addr) begin
                gpioa_addr <= bus.wdata[7:0];
            end
        end
    end

    // registered read data, zero-extended, unmapped reads give zero
    always_ff @(posedge clk) begin
        if (rd) begin
            case (bus.addr)
                gpio_out_addr:  bus.rdata <= word_t'(gpioa_out);
                gpio_addr_addr: bus.rdata <= word_t'(gpioa_addr);
                status_addr:    bus.rdata <= word_t'(uart_busy); // busy in bit 0
                default:        bus.rdata <= '0;
            endcase
        end
    end

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart_tx_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (uart_start),
        .tx_byte (uart_byte),
        .busy    (uart_busy),
        .tx      (uart_tx)
    );

    assign stall = uart_busy; // master waits on this level

    // an accepted byte raises stall at the very same edge
    assert property (@(posedge clk) disable iff (!arst_n) uart_start |=> stall)
        else $error("stall not raised after a uart write");

endmodule : peripheral_block

`default_nettype wire

// ==== soc_memory_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_memory_subsystem #(
    parameter int bram_words   = 1024, // ram depth in words
    parameter int clks_per_bit = 8     // uart bit length in cycles
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              instr_en,    // instruction fetch strobe
    input  soc_pkg::word_t    instr_addr,  // fetch address
    output soc_pkg::word_t    instruction, // fetched word
    input  logic              data_en,     // data access strobe
    input  soc_pkg::byte_en_t data_write,  // byte-write mask, zero reads
    input  soc_pkg::word_t    data_addr,
    input  soc_pkg::word_t    data_wdata,
    output soc_pkg::word_t    data_rdata,
    output logic              stall,       // uart back-pressure
    output soc_pkg::byte_t    gpioa_out,
    output soc_pkg::byte_t    gpioa_addr,
    output logic              uart_tx
);

    data_bus_if cpu_bus ();    // master side, from the plain ports
    data_bus_if bram_bus ();   // decoder to ram
    data_bus_if periph_bus (); // decoder to peripherals

    assign cpu_bus.en    = data_en;
    assign cpu_bus.write = data_write;
    assign cpu_bus.addr  = data_addr;
    assign cpu_bus.wdata = data_wdata;
    assign data_rdata    = cpu_bus.rdata;

    data_bus_decoder data_bus_decoder_i (
        .clk    (clk),
        .arst_n (arst_n),
        .master (cpu_bus.slave),
        .bram   (bram_bus.master),
        .periph (periph_bus.master)
    );

    dual_port_bram #(
        .bram_words (bram_words)
    ) dual_port_bram_i (
        .clk         (clk),
        .instr_en    (instr_en),
        .instr_addr  (instr_addr),
        .instruction (instruction),
        .data        (bram_bus.slave)
    );

    peripheral_block #(
        .clks_per_bit (clks_per_bit)
    ) peripheral_block_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .bus        (periph_bus.slave),
        .gpioa_out  (gpioa_out),
        .gpioa_addr (gpioa_addr),
        .uart_tx    (uart_tx),
        .stall      (stall)
    );

endmodule : soc_memory_subsystem

`default_nettype wire

// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // bus word, used for both addresses and data
    typedef logic [31:0] word_t;

    // one bit per byte lane, bit n writes lane n
    typedef logic [3:0] byte_en_t;

    // gpio data and uart payload
    typedef logic [7:0] byte_t;

    // highest ram address, everything above belongs to the peripherals
    localparam word_t bram_limit = 32'h0000_FFFF;

    // peripheral register map
    localparam word_t gpio_out_addr  = 32'h0001_0000; // gpio output value
    localparam word_t gpio_addr_addr = 32'h0001_0004; // gpio address value
    localparam word_t uart_data_addr = 32'h0001_0008; // write starts a frame
    localparam word_t status_addr    = 32'h0001_000C; // bit 0 is uart busy

endpackage : soc_pkg

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1; // released on the fourth rising edge
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== tb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc;
    import soc_pkg::*;

    localparam int bram_words   = 1024;
    localparam int clks_per_bit = 8;
    localparam int wait_limit   = 200; // cycles allowed for any single wait

    typedef logic [9:0] idx_t; // ram word index

    typedef enum {op_write, op_read, op_fetch, op_uart} op_kind_t;

    typedef struct {
        op_kind_t kind;
        word_t    addr;
        word_t    data; // write data, or the uart byte in bits 7:0
        byte_en_t mask;
        word_t    exp;  // expected peripheral read value
    } op_t;

    logic     clk;
    logic     arst_n;
    logic     instr_en;
    word_t    instr_addr;
    word_t    instruction;
    logic     data_en;
    byte_en_t data_write;
    word_t    data_addr;
    word_t    data_wdata;
    word_t    data_rdata;
    logic     stall;
    byte_t    gpioa_out;
    byte_t    gpioa_addr;
    logic     uart_tx;

    word_t  ram_model [bram_words]; // expected ram contents
    byte_t  exp_gpio_out;           // expected gpio registers
    byte_t  exp_gpio_addr;
    op_t    ops [$];                // stimulus table
    integer seed;
    int     cyc = 0;                // rising edges seen so far

    tb_clock_gen tb_clock_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    soc_memory_subsystem #(
        .bram_words   (bram_words),
        .clks_per_bit (clks_per_bit)
    ) soc_memory_subsystem_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_en    (instr_en),
        .instr_addr  (instr_addr),
        .instruction (instruction),
        .data_en     (data_en),
        .data_write  (data_write),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .stall       (stall),
        .gpioa_out   (gpioa_out),
        .gpioa_addr  (gpioa_addr),
        .uart_tx     (uart_tx)
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) report_fail($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_byte(string name, byte_t got, byte_t exp);
        if (got !== exp) report_fail($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) report_fail($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // word index from address bits above bit 1, wrapped to the depth
    function automatic idx_t word_index(word_t addr);
        return idx_t'((addr >> 2) % bram_words);
    endfunction

    // lane n of the result comes from data when mask bit n is set
    function automatic word_t merge_lanes(word_t old, word_t data, byte_en_t mask);
        word_t r;
        r = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (mask[lane]) r[lane*8 +: 8] = data[lane*8 +: 8];
        end
        return r;
    endfunction

    function automatic word_t random_word_addr();
        word_t r;
        r = $random(seed);
        return (r % bram_words) << 2; // word aligned, inside the ram
    endfunction

    function automatic op_t make_op(op_kind_t kind, word_t addr, word_t data,
                                    byte_en_t mask, word_t exp);
        op_t op;
        op.kind = kind;
        op.addr = addr;
        op.data = data;
        op.mask = mask;
        op.exp  = exp;
        return op;
    endfunction

    // all access tasks start and end on a falling edge
    task automatic write_data(word_t addr, word_t data, byte_en_t mask);
        data_en    = 1'b1;
        data_addr  = addr;
        data_wdata = data;
        data_write = mask;
        @(negedge clk);
        data_en    = 1'b0;
        data_write = '0;
    endtask

    task automatic read_data(word_t addr, output word_t rd);
        data_en    = 1'b1;
        data_addr  = addr;
        data_write = '0;
        @(negedge clk);
        data_en = 1'b0;
        rd      = data_rdata; // registered during the cycle after the access
    endtask

    task automatic fetch_instr(word_t addr, output word_t rd);
        instr_en   = 1'b1;
        instr_addr = addr;
        @(negedge clk);
        instr_en = 1'b0;
        rd       = instruction;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) report_fail("reset was never released");
        end
    endtask

    task automatic wait_stall_low();
        int n;
        n = 0;
        while (stall !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) report_fail("timeout waiting for stall to drop");
        end
    endtask

    task automatic wait_until_cycle(int target);
        int n;
        n = 0;
        while (cyc < target) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) report_fail("timeout waiting for a uart bit");
        end
        if (cyc != target) report_fail("missed the middle of a uart bit");
    endtask

    task automatic send_uart_byte(byte_t b);
        logic [9:0] frame;  // start, eight data bits, stop
        int         n;
        int         start_cyc;
        word_t      rd;
        wait_stall_low();   // previous frame must be over
        write_data(uart_data_addr, {24'h0, b}, 4'h1);
        check_bit("stall", stall, 1'b1);
        n = 0;
        while (uart_tx !== 1'b0) begin // falling edge of the start bit
            @(negedge clk);
            n++;
            if (n > wait_limit) report_fail("timeout waiting for the uart start bit");
        end
        start_cyc = cyc;
        read_data(status_addr, rd);
        check_word("status", rd, 32'h1);
        write_data(uart_data_addr, {24'h0, ~b}, 4'h1); // must be dropped
        for (int k = 0; k < 10; k++) begin
            wait_until_cycle(start_cyc + k * clks_per_bit + clks_per_bit / 2);
            frame[k] = uart_tx;
        end
        check_bit("uart start bit", frame[0], 1'b0);
        check_byte("uart byte", frame[8:1], b);
        check_bit("uart stop bit", frame[9], 1'b1);
        wait_stall_low();
        repeat (2 * clks_per_bit) begin // no second frame follows
            @(negedge clk);
            check_bit("stall", stall, 1'b0);
            check_bit("uart_tx", uart_tx, 1'b1);
        end
    endtask

    task automatic fill_ram();
        for (int i = 0; i < bram_words; i++) begin
            ram_model[i] = $random(seed);
            write_data(word_t'(i << 2), ram_model[i], 4'hF);
        end
    endtask

    task automatic build_table();
        byte_en_t masks [4];
        word_t    a;
        word_t    d;
        masks = '{4'hF, 4'h1, 4'h6, 4'h8};
        foreach (masks[m]) begin // lane writes, data readback, fetch of the same word
            a = random_word_addr();
            d = $random(seed);
            ops.push_back(make_op(op_write, a, d, masks[m], '0));
            ops.push_back(make_op(op_read, a, '0, '0, '0));
            ops.push_back(make_op(op_fetch, a, '0, '0, '0));
        end
        ops.push_back(make_op(op_write, gpio_out_addr, 32'h0000_00A5, 4'h1, '0));
        ops.push_back(make_op(op_write, gpio_addr_addr, 32'h1234_5678, 4'hF, '0));
        ops.push_back(make_op(op_read, gpio_out_addr, '0, '0, 32'h0000_00A5));
        ops.push_back(make_op(op_read, gpio_addr_addr, '0, '0, 32'h0000_0078));
        ops.push_back(make_op(op_write, gpio_out_addr, 32'h0000_005A, 4'h2, '0)); // lane 0 off
        ops.push_back(make_op(op_read, gpio_out_addr, '0, '0, 32'h0000_00A5));
        ops.push_back(make_op(op_read, 32'h0001_0010, '0, '0, '0)); // unmapped
        ops.push_back(make_op(op_write, 32'h0001_0000, 32'h0000_003C, 4'hF, '0));
        ops.push_back(make_op(op_read, 32'h0000_0000, '0, '0, '0)); // ram word 0 untouched
        ops.push_back(make_op(op_write, 32'h0000_FFFC, 32'hDEAD_BEEF, 4'hF, '0));
        ops.push_back(make_op(op_read, 32'h0000_FFFC, '0, '0, '0));
        ops.push_back(make_op(op_fetch, 32'h0000_FFFC, '0, '0, '0));
        ops.push_back(make_op(op_uart, uart_data_addr, 32'h55, 4'h1, '0));
        ops.push_back(make_op(op_uart, uart_data_addr, 32'hA3, 4'h1, '0));
        ops.push_back(make_op(op_uart, uart_data_addr, 32'h00, 4'h1, '0));
        ops.push_back(make_op(op_uart, uart_data_addr, 32'hFF, 4'h1, '0));
    endtask

    task automatic apply_op(op_t op);
        word_t rd;
        word_t exp;
        idx_t  idx;
        idx = word_index(op.addr);
        case (op.kind)
            op_write: begin
                write_data(op.addr, op.data, op.mask);
                if (op.addr <= bram_limit) begin
                    ram_model[idx] = merge_lanes(ram_model[idx], op.data, op.mask);
                end else if (op.mask[0]) begin // only lane 0 is stored
                    if (op.addr == gpio_out_addr) exp_gpio_out = op.data[7:0];
                    if (op.addr == gpio_addr_addr) exp_gpio_addr = op.data[7:0];
                end
                check_byte("gpioa_out", gpioa_out, exp_gpio_out);
                check_byte("gpioa_addr", gpioa_addr, exp_gpio_addr);
            end
            op_read: begin
                read_data(op.addr, rd);
                exp = (op.addr <= bram_limit) ? ram_model[idx] : op.exp;
                check_word("data_rdata", rd, exp);
            end
            op_fetch: begin
                fetch_instr(op.addr, rd);
                check_word("instruction", rd, ram_model[idx]);
            end
            op_uart: send_uart_byte(op.data[7:0]);
            default: report_fail("unknown kind in the stimulus table");
        endcase
    endtask

    initial begin
        instr_en      = 1'b0;
        instr_addr    = '0;
        data_en       = 1'b0;
        data_write    = '0;
        data_addr     = '0;
        data_wdata    = '0;
        exp_gpio_out  = '0;
        exp_gpio_addr = '0;
        seed          = 91;
        wait_reset();
        check_bit("stall", stall, 1'b0);
        check_bit("uart_tx", uart_tx, 1'b1);
        check_byte("gpioa_out", gpioa_out, 8'h00);
        check_byte("gpioa_addr", gpioa_addr, 8'h00);
        fill_ram();
        build_table();
        foreach (ops[i]) apply_op(ops[i]);
        wait_stall_low();
        check_bit("uart_tx", uart_tx, 1'b1);
        $display("TESTS PASSED");
        $finish;
    end

endmodule : tb_soc

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = 8 // clock cycles per bit
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           start,   // load tx_byte and begin a frame
    input  soc_pkg::byte_t tx_byte, // payload, lsb goes out first
    output logic           busy,    // high for the whole frame
    output logic           tx       // serial line, idle high
);
    import soc_pkg::*;

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam int last_bit = 9; // start + 8 data + stop, counted from 0

    logic [cnt_w-1:0] cnt;     // cycles spent in the current bit
    logic [3:0]       bit_idx; // 0 is the start bit, 9 the stop bit
    logic [8:0]       shifter; // remaining data bits with the stop bit on top
    logic             bit_end; // last cycle of the current bit

    assign bit_end = (cnt == cnt_w'(clks_per_bit - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            tx      <= 1'b1; // line idles high
            cnt     <= '0;
            bit_idx <= '0;
            shifter <= '1;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                tx      <= 1'b0;              // start bit goes out at once
                cnt     <= '0;
                bit_idx <= '0;
                shifter <= {1'b1, tx_byte};   // stop bit sits above the data
            end
        end else if (bit_end) begin
            cnt <= '0;
            if (bit_idx == 4'(last_bit)) begin
                busy <= 1'b0; // stop bit done
                tx   <= 1'b1;
            end else begin
                tx      <= shifter[0];
                shifter <= {1'b1, shifter[8:1]}; // fill with idle level
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            cnt <= cnt + cnt_w'(1);
        end
    end

    // the register block must hold off new bytes while a frame runs
    assert property (@(posedge clk) disable iff (!arst_n) busy |-> !start)
        else $error("uart start while busy");

endmodule : uart_tx

`default_nettype wire
